// File: rtl/ucode_pkg.sv
package ucode_pkg;

  // instruction word width
  localparam int inst_width_c = 24;

  // data memory depth in words
  localparam int dmem_els_c = 16;

  // opcodes, any code not listed here executes as a no-op
  typedef enum logic [3:0] {
    LI  = 4'h1,
    ADD = 4'h2,
    SUB = 4'h3,
    LD  = 4'h4,
    ST  = 4'h5,
    BZ  = 4'h6,
    JMP = 4'h7
  } opcode_e;

  typedef logic [15:0] word_t;
  typedef logic [$clog2(dmem_els_c)-1:0] dmem_addr_t;

  // imm is the immediate, the data word index or the branch target
  typedef struct packed {
    opcode_e                 opcode;
    logic [1:0]              rd;
    logic [1:0]              rs;
    logic [1:0]              rt;
    logic [inst_width_c-19:0] pad;
    logic [7:0]              imm;
  } inst_t;

endpackage

// File: rtl/ucode_boot_rom.sv
`timescale 1ns/1ps

module ucode_boot_rom
  import ucode_pkg::*;
  #(parameter int inst_ram_els_p = 32
    , localparam int inst_addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input [inst_addr_width_lp-1:0] addr_i
   , output inst_t                data_o
  );

  // build one instruction word, pad bits stay zero
  function automatic inst_t enc(opcode_e op, logic [1:0] rd, logic [1:0] rs,
                                logic [1:0] rt, logic [7:0] imm);
    inst_t inst;
    inst = '0;
    inst.opcode = op;
    inst.rd = rd;
    inst.rs = rs;
    inst.rt = rt;
    inst.imm = imm;
    return inst;
  endfunction

  always_comb begin
    case (addr_i)
      // poll the command word until it is nonzero
      'd0: data_o = enc(LD, 2'd0, 2'd0, 2'd0, 8'd0);
      'd1: data_o = enc(BZ, 2'd0, 2'd0, 2'd0, 8'd0);
      // operands a and b
      'd2: data_o = enc(LD, 2'd1, 2'd0, 2'd0, 8'd1);
      'd3: data_o = enc(LD, 2'd2, 2'd0, 2'd0, 8'd2);
      // sum to word 3, difference to word 4
      'd4: data_o = enc(ADD, 2'd3, 2'd1, 2'd2, 8'd0);
      'd5: data_o = enc(ST, 2'd0, 2'd3, 2'd0, 8'd3);
      'd6: data_o = enc(SUB, 2'd3, 2'd1, 2'd2, 8'd0);
      'd7: data_o = enc(ST, 2'd0, 2'd3, 2'd0, 8'd4);
      // clear the command word to signal completion
      'd8: data_o = enc(LI, 2'd0, 2'd0, 2'd0, 8'd0);
      'd9: data_o = enc(ST, 2'd0, 2'd0, 2'd0, 8'd0);
      // unused tail of the ROM also jumps back to the poll loop
      default: data_o = enc(JMP, 2'd0, 2'd0, 2'd0, 8'd0);
    endcase
  end

endmodule

// File: rtl/sync_ram_1rw.sv
`timescale 1ns/1ps

module sync_ram_1rw
  #(parameter type elem_t = logic [15:0]
    , parameter int els_p = 16
    , localparam int addr_width_lp = $clog2(els_p)
  )
  (input                       clk_i
   , input                     v_i
   , input                     w_i
   , input [addr_width_lp-1:0] addr_i
   , input elem_t              data_i
   , output elem_t             data_o
  );

  elem_t mem_r [els_p];

  // one access per cycle, read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem_r[addr_i] <= data_i;
      end else begin
        data_o <= mem_r[addr_i];
      end
    end
  end

endmodule

// File: rtl/ucode_pc.sv
`timescale 1ns/1ps

module ucode_pc
  import ucode_pkg::*;
  #(parameter int inst_ram_els_p = 32
    , localparam int inst_addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                                   clk_i
   , input                                 reset_i
   , input                                 branch_taken_i
   , input                                 pc_stall_i
   , input [7:0]                           branch_target_i
   , output inst_t                         inst_o
   , output logic                          inst_v_o
   , output logic [inst_addr_width_lp-1:0] boot_rom_addr_o
   , input inst_t                          boot_rom_data_i
  );

  typedef enum logic [1:0] {
    BOOT,
    BOOT_END,
    FETCH_START,
    FETCH
  } pc_state_e;

  pc_state_e state_r, state_n;

  logic [inst_addr_width_lp-1:0] rom_addr_r, rom_addr_n;
  // pc of the instruction now on inst_o
  logic [inst_addr_width_lp-1:0] ex_pc_r, ex_pc_n;
  logic inst_v_r, inst_v_n;

  // registered instruction RAM controls
  logic ram_v_r, ram_v_n;
  logic ram_w_r, ram_w_n;
  logic [inst_addr_width_lp-1:0] ram_addr_r, ram_addr_n;
  logic [inst_addr_width_lp-1:0] ram_addr;
  inst_t ram_wdata_r;
  logic [inst_addr_width_lp-1:0] target;

  assign target = branch_target_i[inst_addr_width_lp-1:0];
  assign boot_rom_addr_o = rom_addr_r;
  assign inst_v_o = inst_v_r;

  sync_ram_1rw
    #(.elem_t(inst_t)
      ,.els_p(inst_ram_els_p)
      )
    inst_ram
     (.clk_i(clk_i)
      ,.v_i(ram_v_r)
      ,.w_i(ram_w_r)
      ,.addr_i(ram_addr)
      ,.data_i(ram_wdata_r)
      ,.data_o(inst_o)
      );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= BOOT;
      rom_addr_r <= '0;
      ex_pc_r <= '0;
      inst_v_r <= 1'b0;
      ram_v_r <= 1'b0;
      ram_w_r <= 1'b0;
      ram_addr_r <= '0;
    end else begin
      state_r <= state_n;
      rom_addr_r <= rom_addr_n;
      ex_pc_r <= ex_pc_n;
      inst_v_r <= inst_v_n;
      ram_v_r <= ram_v_n;
      ram_w_r <= ram_w_n;
      ram_addr_r <= ram_addr_n;
    end
  end

  // boot data is only consumed while ram_w_r is set
  always_ff @(posedge clk_i) begin
    ram_wdata_r <= boot_rom_data_i;
  end

  always_comb begin
    state_n = state_r;
    rom_addr_n = rom_addr_r;
    ex_pc_n = ex_pc_r;
    inst_v_n = 1'b0;
    ram_v_n = 1'b1;
    ram_w_n = 1'b0;
    ram_addr_n = ram_addr_r;
    // sequential fetch reads the queued address
    ram_addr = ram_addr_r;

    case (state_r)
      BOOT: begin
        // copy one ROM word per cycle, written a cycle later
        ram_w_n = 1'b1;
        ram_addr_n = rom_addr_r;
        rom_addr_n = rom_addr_r + 1'b1;
        if (rom_addr_r == inst_addr_width_lp'(inst_ram_els_p - 1)) begin
          state_n = BOOT_END;
        end
      end
      BOOT_END: begin
        // last word lands this cycle, queue a read of address 0
        ram_addr_n = '0;
        state_n = FETCH_START;
      end
      FETCH_START: begin
        // RAM reads address 0 now, it executes next cycle
        ram_addr_n = inst_addr_width_lp'(1);
        ex_pc_n = '0;
        inst_v_n = 1'b1;
        state_n = FETCH;
      end
      FETCH: begin
        inst_v_n = 1'b1;
        if (pc_stall_i) begin
          // re-read the executing pc so inst_o holds
          ram_addr = ex_pc_r;
        end else if (branch_taken_i) begin
          // target goes out next cycle, target+1 queued behind it
          ram_addr = target;
          ex_pc_n = target;
          ram_addr_n = target + 1'b1;
        end else begin
          ex_pc_n = ram_addr_r;
          ram_addr_n = ram_addr_r + 1'b1;
        end
      end
      default: begin
        state_n = BOOT;
        ram_v_n = 1'b0;
      end
    endcase
  end

endmodule

// File: rtl/ucode_exec.sv
`timescale 1ns/1ps

module ucode_exec
  import ucode_pkg::*;
  (input                clk_i
   , input              reset_i
   , input inst_t       inst_i
   , input              inst_v_i
   , output logic       pc_stall_o
   , output logic       branch_taken_o
   , output logic [7:0] branch_target_o
   , output logic       dmem_req_o
   , output logic       dmem_we_o
   , output dmem_addr_t dmem_addr_o
   , output word_t      dmem_wdata_o
   , input              dmem_gnt_i
   , input              dmem_rvalid_i
   , input word_t       dmem_rdata_i
  );

  word_t regs_r [4];
  // load granted, data due on dmem_rvalid_i
  logic ld_wait_r;
  logic is_ld, is_st, is_bz, is_jmp;
  logic done;
  word_t rs_val, rt_val;

  assign rs_val = regs_r[inst_i.rs];
  assign rt_val = regs_r[inst_i.rt];

  // decode, nothing is active without a valid instruction
  assign is_ld = inst_v_i & (inst_i.opcode == LD);
  assign is_st = inst_v_i & (inst_i.opcode == ST);
  assign is_bz = inst_v_i & (inst_i.opcode == BZ);
  assign is_jmp = inst_v_i & (inst_i.opcode == JMP);

  // branch resolves in the cycle the instruction is presented
  assign branch_taken_o = is_jmp | (is_bz & (rs_val == '0));
  assign branch_target_o = inst_i.imm;

  // load requests once, then waits for its data
  assign dmem_req_o = (is_ld & ~ld_wait_r) | is_st;
  assign dmem_we_o = is_st;
  assign dmem_addr_o = dmem_addr_t'(inst_i.imm);
  assign dmem_wdata_o = rs_val;

  // LD holds until its data returns, ST until granted
  assign pc_stall_o = (is_ld & ~dmem_rvalid_i) | (is_st & ~dmem_gnt_i);
  assign done = inst_v_i & ~pc_stall_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ld_wait_r <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        regs_r[i] <= '0;
      end
    end else begin
      if (ld_wait_r) begin
        ld_wait_r <= ~dmem_rvalid_i;
      end else begin
        ld_wait_r <= is_ld & dmem_gnt_i;
      end

      // writeback only on the completing cycle
      if (done) begin
        case (inst_i.opcode)
          LI: regs_r[inst_i.rd] <= word_t'(inst_i.imm);
          ADD: regs_r[inst_i.rd] <= rs_val + rt_val;
          SUB: regs_r[inst_i.rd] <= rs_val - rt_val;
          LD: regs_r[inst_i.rd] <= dmem_rdata_i;
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
  import ucode_pkg::*;
  (input                clk_i
   , input              reset_i
   , input              eng_req_i
   , input              eng_we_i
   , input dmem_addr_t  eng_addr_i
   , input word_t       eng_wdata_i
   , output logic       eng_gnt_o
   , output logic       eng_rvalid_o
   , input              host_req_i
   , input              host_we_i
   , input dmem_addr_t  host_addr_i
   , input word_t       host_wdata_i
   , output logic       host_gnt_o
   , output logic       host_rvalid_o
   , output word_t      rdata_o
  );

  // set when the host held the last grant
  logic last_host_r;
  // read in flight and which side owns it
  logic rd_v_r, rd_host_r;
  logic ram_v, ram_w;
  dmem_addr_t ram_addr;
  word_t ram_wdata;

  // on a tie the side not granted last time wins
  assign host_gnt_o = host_req_i & (~eng_req_i | ~last_host_r);
  assign eng_gnt_o = eng_req_i & (~host_req_i | last_host_r);

  assign ram_v = eng_gnt_o | host_gnt_o;
  assign ram_w = host_gnt_o ? host_we_i : eng_we_i;
  assign ram_addr = host_gnt_o ? host_addr_i : eng_addr_i;
  assign ram_wdata = host_gnt_o ? host_wdata_i : eng_wdata_i;

  sync_ram_1rw
    #(.elem_t(word_t)
      ,.els_p(dmem_els_c)
      )
    data_ram
     (.clk_i(clk_i)
      ,.v_i(ram_v)
      ,.w_i(ram_w)
      ,.addr_i(ram_addr)
      ,.data_i(ram_wdata)
      ,.data_o(rdata_o)
      );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_host_r <= 1'b0;
      rd_v_r <= 1'b0;
      rd_host_r <= 1'b0;
    end else begin
      if (ram_v) begin
        last_host_r <= host_gnt_o;
      end
      rd_v_r <= ram_v & ~ram_w;
      rd_host_r <= host_gnt_o;
    end
  end

  // read data is valid the cycle after its grant
  assign eng_rvalid_o = rd_v_r & ~rd_host_r;
  assign host_rvalid_o = rd_v_r & rd_host_r;

endmodule

// File: rtl/axil_mem_port.sv
`timescale 1ns/1ps

module axil_mem_port
  import ucode_pkg::*;
  (input                 clk_i
   , input               reset_i
   , input               s_axil_awvalid_i
   , output logic        s_axil_awready_o
   , input [31:0]        s_axil_awaddr_i
   , input               s_axil_wvalid_i
   , output logic        s_axil_wready_o
   , input [31:0]        s_axil_wdata_i
   , output logic        s_axil_bvalid_o
   , input               s_axil_bready_i
   , output logic [1:0]  s_axil_bresp_o
   , input               s_axil_arvalid_i
   , output logic        s_axil_arready_o
   , input [31:0]        s_axil_araddr_i
   , output logic        s_axil_rvalid_o
   , input               s_axil_rready_i
   , output logic [31:0] s_axil_rdata_o
   , output logic [1:0]  s_axil_rresp_o
   , output logic        mem_req_o
   , output logic        mem_we_o
   , output dmem_addr_t  mem_addr_o
   , output word_t       mem_wdata_o
   , input               mem_gnt_i
   , input               mem_rvalid_i
   , input word_t        mem_rdata_i
  );

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RESP
  } port_state_e;

  port_state_e state_r;
  logic rvalid_r;
  logic we_r;
  dmem_addr_t addr_r;
  word_t wdata_r, rdata_r;
  logic wr_start, rd_start;

  // write needs both address and data, and beats a read
  assign wr_start = s_axil_awvalid_i & s_axil_wvalid_i;
  assign rd_start = s_axil_arvalid_i & ~wr_start;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      rvalid_r <= 1'b0;
    end else begin
      case (state_r)
        IDLE: begin
          if (wr_start | rd_start) begin
            state_r <= REQ;
          end
        end
        REQ: begin
          if (mem_gnt_i) begin
            state_r <= RESP;
          end
        end
        RESP: begin
          if (we_r) begin
            if (s_axil_bready_i) begin
              state_r <= IDLE;
            end
          end else if (rvalid_r & s_axil_rready_i) begin
            rvalid_r <= 1'b0;
            state_r <= IDLE;
          end else if (mem_rvalid_i) begin
            rvalid_r <= 1'b1;
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  // capture the transaction while idle, read data when it returns
  always_ff @(posedge clk_i) begin
    if (state_r == IDLE) begin
      we_r <= wr_start;
      addr_r <= wr_start ? s_axil_awaddr_i[5:2] : s_axil_araddr_i[5:2];
      wdata_r <= s_axil_wdata_i[15:0];
    end
    if (mem_rvalid_i) begin
      rdata_r <= mem_rdata_i;
    end
  end

  assign mem_req_o = (state_r == REQ);
  assign mem_we_o = we_r;
  assign mem_addr_o = addr_r;
  assign mem_wdata_o = wdata_r;

  // address channels are accepted together with the grant
  assign s_axil_awready_o = mem_req_o & we_r & mem_gnt_i;
  assign s_axil_wready_o = mem_req_o & we_r & mem_gnt_i;
  assign s_axil_arready_o = mem_req_o & ~we_r & mem_gnt_i;

  // responses are registered and hold until accepted
  assign s_axil_bvalid_o = (state_r == RESP) & we_r;
  assign s_axil_bresp_o = 2'b00;
  assign s_axil_rvalid_o = rvalid_r;
  assign s_axil_rdata_o = {16'h0000, rdata_r};
  assign s_axil_rresp_o = 2'b00;

endmodule

// File: rtl/ucode_engine_top.sv
`timescale 1ns/1ps

module ucode_engine_top
  import ucode_pkg::*;
  #(parameter int inst_ram_els_p = 32
    , localparam int inst_addr_width_lp = $clog2(inst_ram_els_p)
  )
  (input                 clk_i
   , input               reset_i
   , input               s_axil_awvalid_i
   , output logic        s_axil_awready_o
   , input [31:0]        s_axil_awaddr_i
   , input               s_axil_wvalid_i
   , output logic        s_axil_wready_o
   , input [31:0]        s_axil_wdata_i
   , output logic        s_axil_bvalid_o
   , input               s_axil_bready_i
   , output logic [1:0]  s_axil_bresp_o
   , input               s_axil_arvalid_i
   , output logic        s_axil_arready_o
   , input [31:0]        s_axil_araddr_i
   , output logic        s_axil_rvalid_o
   , input               s_axil_rready_i
   , output logic [31:0] s_axil_rdata_o
   , output logic [1:0]  s_axil_rresp_o
  );

  // boot path
  logic [inst_addr_width_lp-1:0] boot_rom_addr;
  inst_t boot_rom_data;

  // fetch and execute
  inst_t inst;
  logic inst_v;
  logic pc_stall, branch_taken;
  logic [7:0] branch_target;

  // engine side of the data memory
  logic eng_req, eng_we, eng_gnt, eng_rvalid;
  dmem_addr_t eng_addr;
  word_t eng_wdata;

  // host side of the data memory
  logic host_req, host_we, host_gnt, host_rvalid;
  dmem_addr_t host_addr;
  word_t host_wdata;
  word_t dmem_rdata;

  ucode_boot_rom #(.inst_ram_els_p(inst_ram_els_p)) boot_rom
    (.addr_i(boot_rom_addr)
     ,.data_o(boot_rom_data)
     );

  ucode_pc #(.inst_ram_els_p(inst_ram_els_p)) pc
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.branch_taken_i(branch_taken)
     ,.pc_stall_i(pc_stall)
     ,.branch_target_i(branch_target)
     ,.inst_o(inst)
     ,.inst_v_o(inst_v)
     ,.boot_rom_addr_o(boot_rom_addr)
     ,.boot_rom_data_i(boot_rom_data)
     );

  ucode_exec exec
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.inst_i(inst)
     ,.inst_v_i(inst_v)
     ,.pc_stall_o(pc_stall)
     ,.branch_taken_o(branch_taken)
     ,.branch_target_o(branch_target)
     ,.dmem_req_o(eng_req)
     ,.dmem_we_o(eng_we)
     ,.dmem_addr_o(eng_addr)
     ,.dmem_wdata_o(eng_wdata)
     ,.dmem_gnt_i(eng_gnt)
     ,.dmem_rvalid_i(eng_rvalid)
     ,.dmem_rdata_i(dmem_rdata)
     );

  mem_arbiter arb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.eng_req_i(eng_req)
     ,.eng_we_i(eng_we)
     ,.eng_addr_i(eng_addr)
     ,.eng_wdata_i(eng_wdata)
     ,.eng_gnt_o(eng_gnt)
     ,.eng_rvalid_o(eng_rvalid)
     ,.host_req_i(host_req)
     ,.host_we_i(host_we)
     ,.host_addr_i(host_addr)
     ,.host_wdata_i(host_wdata)
     ,.host_gnt_o(host_gnt)
     ,.host_rvalid_o(host_rvalid)
     ,.rdata_o(dmem_rdata)
     );

  axil_mem_port host_port
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.s_axil_awvalid_i(s_axil_awvalid_i)
     ,.s_axil_awready_o(s_axil_awready_o)
     ,.s_axil_awaddr_i(s_axil_awaddr_i)
     ,.s_axil_wvalid_i(s_axil_wvalid_i)
     ,.s_axil_wready_o(s_axil_wready_o)
     ,.s_axil_wdata_i(s_axil_wdata_i)
     ,.s_axil_bvalid_o(s_axil_bvalid_o)
     ,.s_axil_bready_i(s_axil_bready_i)
     ,.s_axil_bresp_o(s_axil_bresp_o)
     ,.s_axil_arvalid_i(s_axil_arvalid_i)
     ,.s_axil_arready_o(s_axil_arready_o)
     ,.s_axil_araddr_i(s_axil_araddr_i)
     ,.s_axil_rvalid_o(s_axil_rvalid_o)
     ,.s_axil_rready_i(s_axil_rready_i)
     ,.s_axil_rdata_o(s_axil_rdata_o)
     ,.s_axil_rresp_o(s_axil_rresp_o)
     ,.mem_req_o(host_req)
     ,.mem_we_o(host_we)
     ,.mem_addr_o(host_addr)
     ,.mem_wdata_o(host_wdata)
     ,.mem_gnt_i(host_gnt)
     ,.mem_rvalid_i(host_rvalid)
     ,.mem_rdata_i(dmem_rdata)
     );

endmodule

// File: tests/ucode_engine_assert.sv
`timescale 1ns/1ps

module ucode_engine_assert
  (input          clk_i
   , input        reset_i
   , input        gnt_a_i
   , input        gnt_b_i
   , input        req_i
   , input        gnt_i
   , input        bvalid_i
   , input        bready_i
   , input        rvalid_i
   , input        rready_i
   , input [31:0] rdata_i
  );

  // only one side owns the data RAM in a cycle
  grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    !(gnt_a_i && gnt_b_i))
    else $error("both data memory grants high in one cycle");

  // a request may not be withdrawn before its grant
  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i && !gnt_i |=> req_i)
    else $error("memory request dropped before grant");

  // write response holds under back-pressure
  bvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("BVALID dropped before BREADY");

  // read response and its data hold under back-pressure
  rvalid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("RVALID or RDATA changed before RREADY");

endmodule

// engine side request and the grant pair
bind mem_arbiter ucode_engine_assert arb_assert
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.gnt_a_i(eng_gnt_o)
   ,.gnt_b_i(host_gnt_o)
   ,.req_i(eng_req_i)
   ,.gnt_i(eng_gnt_o)
   ,.bvalid_i(1'b0)
   ,.bready_i(1'b0)
   ,.rvalid_i(1'b0)
   ,.rready_i(1'b0)
   ,.rdata_i(32'h0)
   );

// host side request and the AXI response channels
bind axil_mem_port ucode_engine_assert port_assert
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.gnt_a_i(mem_gnt_i)
   ,.gnt_b_i(1'b0)
   ,.req_i(mem_req_o)
   ,.gnt_i(mem_gnt_i)
   ,.bvalid_i(s_axil_bvalid_o)
   ,.bready_i(s_axil_bready_i)
   ,.rvalid_i(s_axil_rvalid_o)
   ,.rready_i(s_axil_rready_i)
   ,.rdata_i(s_axil_rdata_o)
   );

// File: tests/ucode_engine_tb.sv
`timescale 1ns/1ps

module ucode_engine_tb
  import ucode_pkg::*;
  ;

  localparam int inst_ram_els_p = 32;
  localparam int num_entries_lp = 6;
  // reset, ROM copy and the two setup cycles, with some margin
  localparam int boot_cycles_lp = 4 + inst_ram_els_p + 2 + 16;
  localparam int watchdog_cycles_lp = boot_cycles_lp + 2000 * num_entries_lp;
  localparam logic [1:0] resp_okay_lp = 2'b00;

  logic clk, reset;
  logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic [31:0] s_axil_awaddr, s_axil_wdata;
  logic s_axil_bvalid, s_axil_bready;
  logic [1:0] s_axil_bresp;
  logic s_axil_arvalid, s_axil_arready;
  logic [31:0] s_axil_araddr;
  logic s_axil_rvalid, s_axil_rready;
  logic [31:0] s_axil_rdata;
  logic [1:0] s_axil_rresp;

  int checks = 0;
  int errors = 0;
  logic [31:0] lcg_state = 32'h8128;
  // expected contents of the scratch words
  word_t scratch_exp [dmem_els_c];

  // mailbox commands, a in the upper half and b in the lower half
  logic [31:0] mbox_table [num_entries_lp] = '{
    32'h0000_0000,
    32'hFFFF_0001,
    32'h1234_5678,
    32'h8000_8000,
    32'h00FF_FF00,
    32'h0001_FFFF
  };

  ucode_engine_top #(.inst_ram_els_p(inst_ram_els_p)) dut0
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.s_axil_awvalid_i(s_axil_awvalid)
     ,.s_axil_awready_o(s_axil_awready)
     ,.s_axil_awaddr_i(s_axil_awaddr)
     ,.s_axil_wvalid_i(s_axil_wvalid)
     ,.s_axil_wready_o(s_axil_wready)
     ,.s_axil_wdata_i(s_axil_wdata)
     ,.s_axil_bvalid_o(s_axil_bvalid)
     ,.s_axil_bready_i(s_axil_bready)
     ,.s_axil_bresp_o(s_axil_bresp)
     ,.s_axil_arvalid_i(s_axil_arvalid)
     ,.s_axil_arready_o(s_axil_arready)
     ,.s_axil_araddr_i(s_axil_araddr)
     ,.s_axil_rvalid_o(s_axil_rvalid)
     ,.s_axil_rready_i(s_axil_rready)
     ,.s_axil_rdata_o(s_axil_rdata)
     ,.s_axil_rresp_o(s_axil_rresp)
     );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // 0 to 3 cycles of ready delay, from two middle LCG bits
  function automatic int ready_delay();
    logic [31:0] r;
    r = lcg_next();
    return int'(r[17:16]);
  endfunction

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] actual,
                            input logic [1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic axil_write(input int idx, input logic [31:0] data);
    int delay;
    logic [1:0] held_resp;
    @(negedge clk);
    s_axil_awvalid = 1'b1;
    s_axil_awaddr = 32'(idx) << 2;
    s_axil_wvalid = 1'b1;
    s_axil_wdata = data;
    // address and data are taken on the same edge
    do begin
      @(negedge clk);
      if (s_axil_awready !== s_axil_wready) begin
        report_problem("AWREADY and WREADY did not pulse together");
      end
    end while (s_axil_awready !== 1'b1);
    // handshake happens on the coming rising edge
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b0;
    while (s_axil_bvalid !== 1'b1) begin
      @(negedge clk);
    end
    held_resp = s_axil_bresp;
    delay = ready_delay();
    // response must stay put while BREADY is held off
    repeat (delay) begin
      @(negedge clk);
      if (s_axil_bvalid !== 1'b1) begin
        report_problem("BVALID dropped before BREADY");
      end
      check_resp("BRESP held", s_axil_bresp, held_resp);
    end
    s_axil_bready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    s_axil_bready = 1'b0;
    check_resp("BRESP", held_resp, resp_okay_lp);
  endtask

  task automatic axil_read(input int idx, output word_t data);
    int delay;
    logic [31:0] held_data;
    logic [1:0] held_resp;
    @(negedge clk);
    s_axil_arvalid = 1'b1;
    s_axil_araddr = 32'(idx) << 2;
    do begin
      @(negedge clk);
    end while (s_axil_arready !== 1'b1);
    // address taken on the coming rising edge
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    while (s_axil_rvalid !== 1'b1) begin
      @(negedge clk);
    end
    held_data = s_axil_rdata;
    held_resp = s_axil_rresp;
    delay = ready_delay();
    repeat (delay) begin
      @(negedge clk);
      if (s_axil_rvalid !== 1'b1) begin
        report_problem("RVALID dropped before RREADY");
      end
      check_word("RDATA held", s_axil_rdata[15:0], held_data[15:0]);
      check_resp("RRESP held", s_axil_rresp, held_resp);
    end
    s_axil_rready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    s_axil_rready = 1'b0;
    check_resp("RRESP", held_resp, resp_okay_lp);
    // upper half is zero-extension of the 16-bit word
    check_word("RDATA[31:16]", held_data[31:16], 16'h0000);
    data = held_data[15:0];
  endtask

  initial begin
    repeat (watchdog_cycles_lp) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles_lp);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] value;
    word_t a, b, rd;
    clk = 1'b0;
    reset = 1'b1;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr = '0;
    s_axil_wvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_bready = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr = '0;
    s_axil_rready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // host side handshakes are idle out of reset
    @(negedge clk);
    if ({s_axil_awready, s_axil_wready, s_axil_arready, s_axil_bvalid, s_axil_rvalid} !== '0) begin
      report_problem("AXI ready or valid high after reset");
    end

    // command word must read zero before the engine starts polling
    axil_write(0, 32'h0000_0000);

    // scratch words, upper bits of WDATA are dropped
    for (int i = 5; i < dmem_els_c; i++) begin
      value = lcg_next();
      scratch_exp[i] = value[15:0];
      axil_write(i, value);
      axil_read(i, rd);
      check_word($sformatf("scratch word %0d", i), rd, scratch_exp[i]);
    end

    // mailbox commands back to back, each one issued while the engine polls
    for (int e = 0; e < num_entries_lp; e++) begin
      a = mbox_table[e][31:16];
      b = mbox_table[e][15:0];
      axil_write(1, {16'hDEAD, a});
      axil_write(2, {16'hBEEF, b});
      axil_write(0, 32'(e + 1));
      do begin
        axil_read(0, rd);
      end while (rd !== 16'h0000);
      axil_read(3, rd);
      check_word($sformatf("entry %0d sum (word 3)", e), rd, word_t'(a + b));
      axil_read(4, rd);
      check_word($sformatf("entry %0d difference (word 4)", e), rd, word_t'(a - b));
    end

    // the engine must not have touched the scratch area
    for (int i = 5; i < dmem_els_c; i++) begin
      axil_read(i, rd);
      check_word($sformatf("scratch word %0d after mailbox", i), rd, scratch_exp[i]);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/ucode_pkg.sv
rtl/ucode_boot_rom.sv
rtl/sync_ram_1rw.sv
rtl/ucode_pc.sv
rtl/ucode_exec.sv
rtl/mem_arbiter.sv
rtl/axil_mem_port.sv
rtl/ucode_engine_top.sv
tests/ucode_engine_assert.sv
tests/ucode_engine_tb.sv
